/* fu_cluster.f */
+incdir+include
rtl/fu_isa_pkg.sv
rtl/rob_tag_pkg.sv
rtl/int_alu.sv
rtl/mult_pipe.sv
rtl/wb_queue.sv
rtl/fu_cluster.sv
dv/fu_cluster_assertions.sv
dv/fu_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module fu_cluster_tb \
  -f fu_cluster.f -o fu_cluster_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/fu_cluster_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

/* dv/fu_cluster_tb.sv */
`timescale 1ns/1ps
`include "fu_defs.svh"

module fu_cluster_tb
  import fu_isa_pkg::*;
  import rob_tag_pkg::*;
();

  localparam int CLK_PERIOD    = 10;
  localparam int TAGS          = 1 << `ROB_TAG_BITS;
  localparam int DIRECTED_OPS  = 16 * 4 * 4 * 2;
  localparam int MULT_OPS      = 40;
  localparam int MIXED_OPS     = 200;
  localparam int SQUASH_ROUNDS = 12;
  localparam int BURST         = 8;
  localparam int TOTAL_OPS     = DIRECTED_OPS + MULT_OPS + MIXED_OPS + SQUASH_ROUNDS * BURST;

  logic             clock, reset;
  logic             issue_valid;
  fu_func_e         issue_func;
  op_inst_u         issue_inst;
  logic [`XLEN-1:0] issue_opa, issue_opb;
  opb_sel_e         issue_opb_sel;
  rob_tag_t         issue_tag;
  preg_t            issue_dest;
  logic             squash;
  rob_tag_t         squash_tag, rob_tail;
  logic             wb_valid;
  logic [`XLEN-1:0] wb_result;
  rob_tag_t         wb_tag;
  preg_t            wb_dest;

  integer           seed = 96;
  int               error_count = 0;
  rob_tag_t         next_tag;
  logic             pending [TAGS];     // scoreboard, keyed by tag
  logic [`XLEN-1:0] exp_result [TAGS];
  preg_t            exp_dest [TAGS];

  logic [`XLEN-1:0] opa_set [4] = '{64'hffff_ffff_ffff_fffb, 64'h8000_0000_0000_0000,
                                    64'd123, 64'd0};
  logic [`XLEN-1:0] opb_set [4] = '{64'd0, 64'd63, 64'd7, 64'hffff_ffff_ffff_ffff};

  fu_cluster fu_cluster_i (.*);

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  function automatic logic [`XLEN-1:0] expected_result(fu_func_e func, logic [`XLEN-1:0] a,
      logic [`XLEN-1:0] regb, opb_sel_e sel, logic [31:0] inst);
    logic [`XLEN-1:0] b;
    b = (sel == OPB_IS_LIT) ? {{(`XLEN-8){1'b0}}, inst[20:13]} : regb;
    case (func)
      FU_ADDQ:   return a + b;
      FU_SUBQ:   return a - b;
      FU_AND:    return a & b;
      FU_BIC:    return a & ~b;
      FU_BIS:    return a | b;
      FU_ORNOT:  return a | ~b;
      FU_XOR:    return a ^ b;
      FU_EQV:    return ~(a ^ b);
      FU_SRL:    return a >> b[5:0];
      FU_SLL:    return a << b[5:0];
      FU_SRA:    return $signed(a) >>> b[5:0];
      FU_CMPULT: return {{(`XLEN-1){1'b0}}, a < b};
      FU_CMPEQ:  return {{(`XLEN-1){1'b0}}, a == b};
      FU_CMPULE: return {{(`XLEN-1){1'b0}}, a <= b};
      FU_CMPLT:  return {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      FU_CMPLE:  return {{(`XLEN-1){1'b0}}, $signed(a) <= $signed(b)};
      FU_MULQ:   return a * b;  // low half only
      default:   return '0;
    endcase
  endfunction

  // age relative to the branch, modulo the ROB size
  function automatic logic is_younger(rob_tag_t tag, rob_tag_t branch, rob_tag_t tail);
    int age;
    int window;
    age    = (int'(tag) - int'(branch) + TAGS) % TAGS;
    window = (int'(tail) - int'(branch) + TAGS) % TAGS;
    return (age > 0) && (age <= window);
  endfunction

  function automatic logic any_pending();
    for (int t = 0; t < TAGS; t++)
      if (pending[t])
        return 1'b1;
    return 1'b0;
  endfunction

  function automatic logic [`XLEN-1:0] random_operand();
    case ($unsigned($random(seed)) % 6)
      0:       return '0;
      1:       return '1;
      2:       return {1'b1, 31'($random(seed)), 32'($random(seed))};  // negative
      default: return {32'($random(seed)), 32'($random(seed))};
    endcase
  endfunction

  task automatic check_value(string what, logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] t=%0d ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic drive_idle();
    @(negedge clock);
    issue_valid = 1'b0;
    squash      = 1'b0;
  endtask

  task automatic issue_op(fu_func_e func, logic [`XLEN-1:0] a, logic [`XLEN-1:0] b,
                          opb_sel_e sel, logic [7:0] lit);
    logic [31:0] inst;
    if (sel == OPB_IS_LIT)
      inst = {6'h11, 5'd1, lit, 1'b1, 2'b00, func, 5'd3};
    else
      inst = {6'h11, 5'd1, 5'd2, 3'b000, 1'b0, 2'b00, func, 5'd3};
    @(negedge clock);
    issue_valid   = 1'b1;
    issue_func    = func;
    issue_inst    = inst;
    issue_opa     = a;
    issue_opb     = b;
    issue_opb_sel = sel;
    issue_tag     = next_tag;
    issue_dest    = preg_t'($random(seed));
    squash        = 1'b0;
    rob_tail      = next_tag;  // tail tracks the youngest op
    exp_result[next_tag] = expected_result(func, a, b, sel, inst);
    exp_dest[next_tag]   = issue_dest;
    pending[next_tag]    = 1'b1;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic issue_random(int mul_odds);
    fu_func_e func;
    opb_sel_e sel;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    if ($unsigned($random(seed)) % mul_odds == 0)
      func = FU_MULQ;
    else
      func = fu_func_e'({1'b0, 4'($random(seed))});
    sel = opb_sel_e'(1'($random(seed)));
    a   = random_operand();
    b   = random_operand();
    issue_op(func, a, b, sel, 8'($random(seed)));
  endtask

  // burst, optional gap, then a branch somewhere inside the burst squashes
  task automatic squash_round();
    int gap;
    int depth;
    gap   = $unsigned($random(seed)) % 4;
    depth = 1 + $unsigned($random(seed)) % (BURST - 1);
    for (int i = 0; i < BURST; i++)
      issue_random(2);
    repeat (gap) drive_idle();
    squash     = 1'b1;  // gap 0 lands on the last issue cycle
    squash_tag = rob_tail - rob_tag_t'(depth);
    @(posedge clock);
    for (int t = 0; t < TAGS; t++)
      if (pending[t] && is_younger(rob_tag_t'(t), squash_tag, rob_tail))
        pending[t] = 1'b0;
    drive_idle();
  endtask

  always @(negedge clock) begin
    if (wb_valid) begin
      check_value($sformatf("scoreboard entry for tag %0d", wb_tag), pending[wb_tag], 1);
      check_value($sformatf("result of tag %0d", wb_tag), wb_result, exp_result[wb_tag]);
      check_value($sformatf("dest of tag %0d", wb_tag), wb_dest, exp_dest[wb_tag]);
      pending[wb_tag] = 1'b0;
    end
  end

  initial begin
    #(TOTAL_OPS * 20 * CLK_PERIOD + 100 * CLK_PERIOD);
    $display("watchdog timeout: results still outstanding at %0d ns", $time);
    $display("Simulation failed");
    $fatal(1, "watchdog");
  end

  initial begin
    reset         = 1'b1;
    issue_valid   = 1'b0;
    issue_func    = FU_ADDQ;
    issue_inst    = '0;
    issue_opa     = '0;
    issue_opb     = '0;
    issue_opb_sel = OPB_IS_REGB;
    issue_tag     = '0;
    issue_dest    = '0;
    squash        = 1'b0;
    squash_tag    = '0;
    rob_tail      = '0;
    next_tag      = '0;
    for (int t = 0; t < TAGS; t++)
      pending[t] = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    repeat (5) drive_idle();  // nothing issued, wb must stay quiet

    for (int f = 0; f < 16; f++)
      for (int i = 0; i < 4; i++)
        for (int j = 0; j < 4; j++) begin
          issue_op(fu_func_e'(f), opa_set[i], opb_set[j], OPB_IS_REGB, 8'h5a);
          issue_op(fu_func_e'(f), opa_set[i], random_operand(), OPB_IS_LIT,
                   opb_set[j][7:0]);
        end
    drive_idle();

    repeat (MULT_OPS) issue_random(1);  // back to back multiplies
    drive_idle();

    repeat (MIXED_OPS) begin
      issue_random(3);
      if (($random(seed) & 7) == 0)
        drive_idle();
    end
    drive_idle();

    repeat (SQUASH_ROUNDS) squash_round();

    while (any_pending())
      drive_idle();
    repeat (10) drive_idle();  // catch any stray writeback

    if (error_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* dv/fu_cluster_assertions.sv */
`timescale 1ns/1ps
`include "fu_defs.svh"

module fu_cluster_assertions (
  input logic                             clock,
  input logic                             reset,
  input logic [$clog2(`WB_QUEUE_DEPTH):0] count,
  input logic                             push_mult,
  input logic                             push_alu,
  input logic                             pop,
  input logic                             wb_valid
);

  localparam int DEPTH = `WB_QUEUE_DEPTH;

  int occupancy_next;  // slots taken after this cycle's pushes and pop

  assign occupancy_next = int'(count) + int'(push_mult) + int'(push_alu) - int'(pop);

  no_overflow: assert property (@(posedge clock) disable iff (reset)
    count <= DEPTH)
    else $error("writeback queue holds more entries than it has slots");

  wb_low_in_reset: assert property (@(posedge clock)
    reset |=> !wb_valid)
    else $error("wb_valid high while reset is applied");

  // first cycle out of reset
  wb_low_after_reset: assert property (@(posedge clock)
    $fell(reset) |=> !wb_valid)
    else $error("wb_valid high in the cycle after reset");

  write_finds_room: assert property (@(posedge clock) disable iff (reset)
    (push_mult || push_alu) |-> occupancy_next <= DEPTH)
    else $error("result written into a full writeback queue");

endmodule

bind wb_queue fu_cluster_assertions wbq_checks (
  .clock, .reset, .count, .push_mult, .push_alu, .pop, .wb_valid
);

/* rtl/fu_cluster.sv */
`timescale 1ns/1ps
`include "fu_defs.svh"

module fu_cluster
  import fu_isa_pkg::*;
  import rob_tag_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_valid,
  input  fu_func_e         issue_func,
  input  op_inst_u         issue_inst,
  input  logic [`XLEN-1:0] issue_opa,
  input  logic [`XLEN-1:0] issue_opb,
  input  opb_sel_e         issue_opb_sel,
  input  rob_tag_t         issue_tag,
  input  preg_t            issue_dest,
  input  logic             squash,
  input  rob_tag_t         squash_tag,
  input  rob_tag_t         rob_tail,
  output logic             wb_valid,
  output logic [`XLEN-1:0] wb_result,
  output rob_tag_t         wb_tag,
  output preg_t            wb_dest
);

  logic             alu_done, mult_done;
  logic [`XLEN-1:0] alu_result, mult_result;
  rob_tag_t         alu_tag, mult_tag;
  preg_t            alu_dest, mult_dest;

  int_alu alu_u (
    .clock, .reset,
    .issue_valid, .issue_func, .issue_inst, .issue_opa, .issue_opb,
    .issue_opb_sel, .issue_tag, .issue_dest,
    .squash, .squash_tag, .rob_tail,
    .alu_done, .alu_result, .alu_tag, .alu_dest
  );

  mult_pipe mult_u (
    .clock, .reset,
    .issue_valid, .issue_func, .issue_inst, .issue_opa, .issue_opb,
    .issue_opb_sel, .issue_tag, .issue_dest,
    .squash, .squash_tag, .rob_tail,
    .mult_done, .mult_result, .mult_tag, .mult_dest
  );

  // merges both completion streams onto the single wb port
  wb_queue wbq_u (
    .clock, .reset,
    .alu_done, .alu_result, .alu_tag, .alu_dest,
    .mult_done, .mult_result, .mult_tag, .mult_dest,
    .squash, .squash_tag, .rob_tail,
    .wb_valid, .wb_result, .wb_tag, .wb_dest
  );

endmodule

/* rtl/wb_queue.sv */
`timescale 1ns/1ps
`include "fu_defs.svh"

module wb_queue
  import rob_tag_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             alu_done,
  input  logic [`XLEN-1:0] alu_result,
  input  rob_tag_t         alu_tag,
  input  preg_t            alu_dest,
  input  logic             mult_done,
  input  logic [`XLEN-1:0] mult_result,
  input  rob_tag_t         mult_tag,
  input  preg_t            mult_dest,
  input  logic             squash,
  input  rob_tag_t         squash_tag,
  input  rob_tag_t         rob_tail,
  output logic             wb_valid,
  output logic [`XLEN-1:0] wb_result,
  output rob_tag_t         wb_tag,
  output preg_t            wb_dest
);

  localparam int DEPTH = `WB_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  logic [PTR_W-1:0] head, tail, alu_slot;
  logic [PTR_W:0]   count;          // occupied slots, squashed ones included
  logic [DEPTH-1:0] entry_valid;
  logic [`XLEN-1:0] entry_result [DEPTH];
  rob_tag_t         entry_tag [DEPTH];
  preg_t            entry_dest [DEPTH];

  logic       take_mult, take_alu;
  logic       empty, pop, head_live;
  logic       bypass_mult, bypass_alu;
  logic       push_mult, push_alu;
  logic [1:0] push_count;

  assign take_mult = mult_done && !(squash && is_squashed(mult_tag, squash_tag, rob_tail));
  assign take_alu  = alu_done && !(squash && is_squashed(alu_tag, squash_tag, rob_tail));

  assign empty     = (count == '0);
  assign pop       = !empty;  // head slot leaves every cycle, dead or alive
  assign head_live = !empty && entry_valid[head] &&
                     !(squash && is_squashed(entry_tag[head], squash_tag, rob_tail));

  // empty queue, newest result goes straight to the wb registers
  assign bypass_mult = empty && take_mult;
  assign bypass_alu  = empty && take_alu && !take_mult;
  assign push_mult   = take_mult && !bypass_mult;
  assign push_alu    = take_alu && !bypass_alu;
  assign push_count  = {1'b0, push_mult} + {1'b0, push_alu};
  assign alu_slot    = push_mult ? tail + 1'b1 : tail;  // mult goes in first

  always_ff @(posedge clock) begin
    if (reset) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      entry_valid <= '0;
      wb_valid    <= 1'b0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (squash && is_squashed(entry_tag[i], squash_tag, rob_tail))
          entry_valid[i] <= 1'b0;
      end
      if (pop)
        entry_valid[head] <= 1'b0;
      if (push_mult)
        entry_valid[tail] <= 1'b1;
      if (push_alu)
        entry_valid[alu_slot] <= 1'b1;
      head     <= head + PTR_W'(pop);
      tail     <= tail + PTR_W'(push_count);
      count    <= count + (PTR_W+1)'(push_count) - (PTR_W+1)'(pop);
      wb_valid <= head_live || bypass_mult || bypass_alu;
    end
  end

  always_ff @(posedge clock) begin
    if (push_mult) begin
      entry_result[tail] <= mult_result;
      entry_tag[tail]    <= mult_tag;
      entry_dest[tail]   <= mult_dest;
    end
    if (push_alu) begin
      entry_result[alu_slot] <= alu_result;
      entry_tag[alu_slot]    <= alu_tag;
      entry_dest[alu_slot]   <= alu_dest;
    end
    if (head_live) begin
      wb_result <= entry_result[head];
      wb_tag    <= entry_tag[head];
      wb_dest   <= entry_dest[head];
    end else if (bypass_mult) begin
      wb_result <= mult_result;
      wb_tag    <= mult_tag;
      wb_dest   <= mult_dest;
    end else if (bypass_alu) begin
      wb_result <= alu_result;
      wb_tag    <= alu_tag;
      wb_dest   <= alu_dest;
    end
  end

endmodule

/* rtl/mult_pipe.sv */
`timescale 1ns/1ps
`include "fu_defs.svh"

module mult_pipe
  import fu_isa_pkg::*;
  import rob_tag_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_valid,
  input  fu_func_e         issue_func,
  input  op_inst_u         issue_inst,
  input  logic [`XLEN-1:0] issue_opa,
  input  logic [`XLEN-1:0] issue_opb,
  input  opb_sel_e         issue_opb_sel,
  input  rob_tag_t         issue_tag,
  input  preg_t            issue_dest,
  input  logic             squash,
  input  rob_tag_t         squash_tag,
  input  rob_tag_t         rob_tail,
  output logic             mult_done,
  output logic [`XLEN-1:0] mult_result,
  output rob_tag_t         mult_tag,
  output preg_t            mult_dest
);

  localparam int SLICE = `XLEN / `MULT_STAGES;  // multiplier bits per stage
  localparam int LAST  = `MULT_STAGES - 1;

  logic [`XLEN-1:0] opb;
  logic             start;

  assign opb   = opb_value(issue_opb_sel, issue_opb, issue_inst);
  assign start = issue_valid && (issue_func == FU_MULQ) &&
                 !(squash && is_squashed(issue_tag, squash_tag, rob_tail));

  for (genvar s = 0; s < `MULT_STAGES; s++) begin : g_stage
    logic [`XLEN-1:0] prod_in, mplier_in, mcand_in, partial;
    logic             valid_in;
    rob_tag_t         tag_in;
    preg_t            dest_in;
    logic [`XLEN-1:0] prod_q, mplier_q, mcand_q;
    logic             valid_q;
    rob_tag_t         tag_q;
    preg_t            dest_q;

    if (s == 0) begin : g_first
      assign prod_in   = '0;
      assign mplier_in = issue_opa;
      assign mcand_in  = opb;
      assign valid_in  = start;
      assign tag_in    = issue_tag;
      assign dest_in   = issue_dest;
    end else begin : g_next
      assign prod_in   = g_stage[s-1].prod_q;
      assign mplier_in = g_stage[s-1].mplier_q;
      assign mcand_in  = g_stage[s-1].mcand_q;
      assign tag_in    = g_stage[s-1].tag_q;
      assign dest_in   = g_stage[s-1].dest_q;
      // younger ops die on their way into the next stage
      assign valid_in  = g_stage[s-1].valid_q &&
                         !(squash && is_squashed(g_stage[s-1].tag_q, squash_tag, rob_tail));
    end

    // low slice of the multiplier times the already shifted multiplicand
    assign partial = mplier_in[SLICE-1:0] * mcand_in;

    always_ff @(posedge clock) begin
      if (reset)
        valid_q <= 1'b0;
      else
        valid_q <= valid_in;
    end

    always_ff @(posedge clock) begin
      if (valid_in) begin
        prod_q   <= prod_in + partial;
        mplier_q <= mplier_in >> SLICE;
        mcand_q  <= mcand_in << SLICE;
        tag_q    <= tag_in;
        dest_q   <= dest_in;
      end
    end
  end

  assign mult_done   = g_stage[LAST].valid_q &&
                       !(squash && is_squashed(g_stage[LAST].tag_q, squash_tag, rob_tail));
  assign mult_result = g_stage[LAST].prod_q;  // low XLEN bits of the product
  assign mult_tag    = g_stage[LAST].tag_q;
  assign mult_dest   = g_stage[LAST].dest_q;

endmodule

/* rtl/int_alu.sv */
`timescale 1ns/1ps
`include "fu_defs.svh"

module int_alu
  import fu_isa_pkg::*;
  import rob_tag_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_valid,
  input  fu_func_e         issue_func,
  input  op_inst_u         issue_inst,
  input  logic [`XLEN-1:0] issue_opa,
  input  logic [`XLEN-1:0] issue_opb,
  input  opb_sel_e         issue_opb_sel,
  input  rob_tag_t         issue_tag,
  input  preg_t            issue_dest,
  input  logic             squash,
  input  rob_tag_t         squash_tag,
  input  rob_tag_t         rob_tail,
  output logic             alu_done,
  output logic [`XLEN-1:0] alu_result,
  output rob_tag_t         alu_tag,
  output preg_t            alu_dest
);

  logic [`XLEN-1:0] opa, opb, result;
  logic             accept;
  logic             done_q;

  function automatic logic signed_lt(logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
    if (a[`XLEN-1] == b[`XLEN-1])
      return a < b;      // same sign, unsigned compare works
    return a[`XLEN-1];   // negative one is smaller
  endfunction

  assign opa = issue_opa;
  assign opb = opb_value(issue_opb_sel, issue_opb, issue_inst);

  always_comb begin
    case (issue_func)
      FU_ADDQ:   result = opa + opb;
      FU_SUBQ:   result = opa - opb;
      FU_AND:    result = opa & opb;
      FU_BIC:    result = opa & ~opb;
      FU_BIS:    result = opa | opb;
      FU_ORNOT:  result = opa | ~opb;
      FU_XOR:    result = opa ^ opb;
      FU_EQV:    result = opa ^ ~opb;
      FU_SRL:    result = opa >> opb[5:0];
      FU_SLL:    result = opa << opb[5:0];
      // sign fill shifted in from the top; shift of 64 leaves nothing
      FU_SRA:    result = (opa >> opb[5:0]) | ({`XLEN{opa[`XLEN-1]}} << (`XLEN - opb[5:0]));
      FU_CMPULT: result = {{(`XLEN-1){1'b0}}, opa < opb};
      FU_CMPEQ:  result = {{(`XLEN-1){1'b0}}, opa == opb};
      FU_CMPULE: result = {{(`XLEN-1){1'b0}}, opa <= opb};
      FU_CMPLT:  result = {{(`XLEN-1){1'b0}}, signed_lt(opa, opb)};
      FU_CMPLE:  result = {{(`XLEN-1){1'b0}}, signed_lt(opa, opb) || (opa == opb)};
      default:   result = '0;  // mulq, not ours
    endcase
  end

  assign accept = issue_valid && (issue_func != FU_MULQ) &&
                  !(squash && is_squashed(issue_tag, squash_tag, rob_tail));

  always_ff @(posedge clock) begin
    if (reset)
      done_q <= 1'b0;
    else
      done_q <= accept;
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      alu_result <= result;
      alu_tag    <= issue_tag;
      alu_dest   <= issue_dest;
    end
  end

  // drop the held result if a squash lands while it is presented
  assign alu_done = done_q && !(squash && is_squashed(alu_tag, squash_tag, rob_tail));

endmodule

/* rtl/rob_tag_pkg.sv */
`include "fu_defs.svh"

package rob_tag_pkg;

  typedef logic [`ROB_TAG_BITS-1:0] rob_tag_t;
  typedef logic [`PREG_BITS-1:0]    preg_t;

  // younger than the branch and not past the tail, all modulo ROB size
  function automatic logic is_squashed(rob_tag_t tag, rob_tag_t squash_tag,
                                       rob_tag_t rob_tail);
    rob_tag_t entry_dist;
    rob_tag_t tail_dist;
    entry_dist = tag - squash_tag;
    tail_dist  = rob_tail - squash_tag;
    return (entry_dist != '0) && (entry_dist <= tail_dist);
  endfunction

endpackage

/* rtl/fu_isa_pkg.sv */
`include "fu_defs.svh"

package fu_isa_pkg;

  typedef enum logic [4:0] {
    FU_ADDQ   = 5'h00,
    FU_SUBQ   = 5'h01,
    FU_AND    = 5'h02,
    FU_BIC    = 5'h03,
    FU_BIS    = 5'h04,
    FU_ORNOT  = 5'h05,
    FU_XOR    = 5'h06,
    FU_EQV    = 5'h07,
    FU_SRL    = 5'h08,
    FU_SLL    = 5'h09,
    FU_SRA    = 5'h0a,
    FU_CMPULT = 5'h0b,
    FU_CMPEQ  = 5'h0c,
    FU_CMPULE = 5'h0d,
    FU_CMPLT  = 5'h0e,
    FU_CMPLE  = 5'h0f,
    FU_MULQ   = 5'h10  // only the multiplier takes this one
  } fu_func_e;

  typedef enum logic {
    OPB_IS_REGB = 1'b0,
    OPB_IS_LIT  = 1'b1
  } opb_sel_e;

  // operate format; bit 12 tells register form from literal form
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] ra;
      logic [4:0] rb;
      logic [2:0] sbz;       // must be zero
      logic       lit_flag;
      logic [6:0] func;
      logic [4:0] rc;
    } r;
    struct packed {
      logic [5:0] opcode;
      logic [4:0] ra;
      logic [7:0] lit;       // zero-extended to XLEN
      logic       lit_flag;
      logic [6:0] func;
      logic [4:0] rc;
    } i;
  } op_inst_u;

  function automatic logic [`XLEN-1:0] opb_value(opb_sel_e sel, logic [`XLEN-1:0] regb,
                                                 op_inst_u inst);
    if (sel == OPB_IS_LIT)
      return {{(`XLEN-8){1'b0}}, inst.i.lit};
    return regb;
  endfunction

endpackage

/* include/fu_defs.svh */
`ifndef FU_DEFS_SVH
`define FU_DEFS_SVH

// datapath width
`define XLEN 64

// ROB tag and physical register index widths
`define ROB_TAG_BITS 5
`define PREG_BITS 6

// must divide XLEN evenly
`define MULT_STAGES 4

// power of two, pointers wrap naturally
`define WB_QUEUE_DEPTH 4

`endif
